// File: source/lsu_defs.svh
// Width, SRAM size and SRAM latency macros for the load/store unit
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Datapath
`define LSU_DW 32
`define LSU_AW 32

// Command SRAM
`define SRAM_BYTES 4096
`define SRAM_DELAY 3 // Cycles from command to response

`endif

// File: source/lsu_isa_pkg.sv
// Memory opcode and access size enums of the load/store instructions
package lsu_isa_pkg;

   // Load and store opcodes
   typedef enum logic [2:0] {
      LB,  // Byte, sign-extended
      LBU, // Byte, zero-extended
      LH,  // Halfword, sign-extended
      LHU, // Halfword, zero-extended
      LW,
      SB,
      SH,
      SW
   } mem_op_e;

   // Size code as seen on the SRAM command
   typedef enum logic [2:0] {
      SZ_BYTE = 3'd1,
      SZ_HALF = 3'd2,
      SZ_WORD = 3'd3
   } mem_size_e;

endpackage

// File: source/lsu_pipe_pkg.sv
// Structs carried between the decode, execute, SRAM and result stages
`include "lsu_defs.svh"

package lsu_pipe_pkg;

   // Decoded access
   typedef struct packed {
      logic [`LSU_AW-1:0]    addr;
      lsu_isa_pkg::mem_size_e size;
      logic                  write;
      logic                  sext;  // Sign-extend load data
      logic [`LSU_DW-1:0]    wdata;
      logic                  fault; // Misaligned
   } dec_op_t;

   // SRAM command
   typedef struct packed {
      logic [`LSU_AW-1:0]    addr;
      lsu_isa_pkg::mem_size_e size;
      logic                  write;
      logic [`LSU_DW-1:0]    wdata;
   } mem_cmd_t;

   // Raw SRAM answer, still to be extended
   typedef struct packed {
      logic [`LSU_DW-1:0]    data;
      lsu_isa_pkg::mem_size_e size;
      logic                  sext;
   } ld_rsp_t;

endpackage

// File: source/lsu_decode.sv
// Decode stage: effective address, size and extension rule, alignment check
`include "lsu_defs.svh"

module lsu_decode (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   insn_valid,
   input  lsu_isa_pkg::mem_op_e   opcode,
   input  logic [`LSU_AW-1:0]     base,
   input  logic [11:0]            offset,
   input  logic [`LSU_DW-1:0]     store_data,
   input  logic                   busy,
   output logic                   dec_valid,
   output lsu_pipe_pkg::dec_op_t  dec_op
);
   import lsu_isa_pkg::*;

   logic               accept;
   logic [`LSU_AW-1:0] ea;
   mem_size_e          acc_size;
   logic               acc_write;
   logic               acc_sext;
   logic               misaligned;

   assign accept = insn_valid & ~busy; // Strobes during an access are dropped
   assign ea = base + {{(`LSU_AW-12){offset[11]}}, offset};

   always_comb begin
      acc_size  = SZ_WORD;
      acc_write = 1'b0;
      acc_sext  = 1'b0;
      case (opcode)
         LB:  begin acc_size = SZ_BYTE; acc_sext = 1'b1; end
         LBU: acc_size = SZ_BYTE;
         LH:  begin acc_size = SZ_HALF; acc_sext = 1'b1; end
         LHU: acc_size = SZ_HALF;
         LW:  acc_size = SZ_WORD;
         SB:  begin acc_size = SZ_BYTE; acc_write = 1'b1; end
         SH:  begin acc_size = SZ_HALF; acc_write = 1'b1; end
         SW:  begin acc_size = SZ_WORD; acc_write = 1'b1; end
         default: acc_size = SZ_WORD;
      endcase
   end

   always_comb begin
      case (acc_size)
         SZ_HALF: misaligned = ea[0];
         SZ_WORD: misaligned = |ea[1:0];
         default: misaligned = 1'b0; // Bytes never fault
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= accept;
      end
   end

   // Held stable until the next accepted strobe
   always_ff @(posedge clk) begin
      if (accept) begin
         dec_op <= '{addr: ea, size: acc_size, write: acc_write, sext: acc_sext,
                     wdata: store_data, fault: misaligned};
      end
   end

   a_opcode_known: assert property (@(posedge clk) disable iff (!arst_n)
      accept |-> opcode inside {LB, LBU, LH, LHU, LW, SB, SH, SW})
      else $error("lsu_decode: undefined opcode accepted");

endmodule

// File: source/lsu_execute.sv
// Execute stage: SRAM command handshake, response capture and fault bypass
`include "lsu_defs.svh"

module lsu_execute (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    dec_valid,
   input  lsu_pipe_pkg::dec_op_t   dec_op,
   output logic                    cmd_valid,
   input  logic                    cmd_ready,
   output lsu_pipe_pkg::mem_cmd_t  cmd,
   input  logic                    rsp_valid,
   output logic                    rsp_ready,
   input  logic [`LSU_DW-1:0]      rd_data,
   output logic                    ld_valid,
   output lsu_pipe_pkg::ld_rsp_t   ld_rsp,
   output logic                    flt_valid,
   output logic                    busy
);
   import lsu_pipe_pkg::*;

   typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_e;

   state_e  state;
   state_e  state_nxt;
   dec_op_t op_r;
   dec_op_t cur_op;
   logic    start;
   logic    cmd_fire;
   logic    rsp_fire;

   // Command goes out in the decode cycle itself
   assign cur_op = (state == IDLE) ? dec_op : op_r;
   assign start = (state == IDLE) & dec_valid & ~dec_op.fault;

   assign cmd_valid = start | (state == ISSUE);
   assign cmd = '{addr: cur_op.addr, size: cur_op.size, write: cur_op.write,
                  wdata: cur_op.wdata};
   assign rsp_ready = (state == WAIT);

   assign cmd_fire = cmd_valid & cmd_ready;
   assign rsp_fire = rsp_valid & rsp_ready;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:  if (start) state_nxt = cmd_fire ? WAIT : ISSUE;
         ISSUE: if (cmd_fire) state_nxt = WAIT;
         WAIT:  if (rsp_fire) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= IDLE;
         ld_valid  <= 1'b0;
         flt_valid <= 1'b0;
      end else begin
         state     <= state_nxt;
         ld_valid  <= rsp_fire;
         flt_valid <= (state == IDLE) & dec_valid & dec_op.fault;
      end
   end

   always_ff @(posedge clk) begin
      if ((state == IDLE) && dec_valid) begin
         op_r <= dec_op;
      end
      if (rsp_fire) begin
         // Stores report completion only
         ld_rsp <= '{data: rd_data & {`LSU_DW{~op_r.write}}, size: op_r.size,
                     sext: op_r.sext & ~op_r.write};
      end
   end

   assign busy = (state != IDLE) | ld_valid | flt_valid;

   a_no_cmd_on_fault: assert property (@(posedge clk) disable iff (!arst_n)
      dec_valid && dec_op.fault |-> !cmd_valid)
      else $error("lsu_execute: command issued for a faulted access");

endmodule

// File: source/cmd_sram.sv
// Byte-addressed SRAM with command/response handshakes and fixed latency
`include "lsu_defs.svh"

module cmd_sram #(
   parameter int DELAY = `SRAM_DELAY
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    cmd_valid,
   output logic                    cmd_ready,
   input  lsu_pipe_pkg::mem_cmd_t  cmd,
   output logic                    rsp_valid,
   input  logic                    rsp_ready,
   output logic [`LSU_DW-1:0]      rd_data
);
   import lsu_isa_pkg::*;
   import lsu_pipe_pkg::*;

   localparam int CW = $clog2(DELAY + 1);
   localparam int IW = $clog2(`SRAM_BYTES);
   localparam int NB = `LSU_DW / 8;

   logic [7:0]         mem [0:`SRAM_BYTES-1];
   logic [CW-1:0]      cnt;
   logic [CW-1:0]      cnt_nxt;
   mem_cmd_t           cmd_r;
   mem_cmd_t           cur;
   logic               push;
   logic               pop;
   logic               arrive;
   logic [IW-1:0]      base_idx;
   logic [2:0]         nbytes;
   logic [`LSU_DW-1:0] rd_nxt;

   initial begin
      for (int i = 0; i < `SRAM_BYTES; i++) begin
         mem[i] = 8'h00;
      end
   end

   assign push = cmd_valid & cmd_ready;
   assign pop  = rsp_valid & rsp_ready;

   assign cmd_ready = (cnt == '0);
   assign rsp_valid = (cnt == CW'(DELAY));

   always_comb begin
      if (cnt == '0) begin
         cnt_nxt = push ? CW'(1) : '0;
      end else if (cnt < CW'(DELAY)) begin
         cnt_nxt = cnt + CW'(1);
      end else begin
         cnt_nxt = pop ? '0 : cnt; // Hold response until taken
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt <= '0;
      end else begin
         cnt <= cnt_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         cmd_r <= cmd;
      end
   end

   // With DELAY of 1 the command is served on its own transfer edge
   assign cur = push ? cmd : cmd_r;
   assign arrive = (cnt_nxt == CW'(DELAY)) && (cnt != CW'(DELAY));
   assign base_idx = cur.addr[IW-1:0]; // Upper address bits wrap

   always_comb begin
      case (cur.size)
         SZ_BYTE: nbytes = 3'd1;
         SZ_HALF: nbytes = 3'd2;
         default: nbytes = 3'd4;
      endcase
   end

   always_comb begin
      rd_nxt = '0; // Unused upper lanes read as zero
      for (int i = 0; i < NB; i++) begin
         if (i < nbytes) begin
            rd_nxt[8*i +: 8] = mem[base_idx + IW'(i)];
         end
      end
   end

   always @(posedge clk) begin
      if (arrive && cur.write) begin
         for (int i = 0; i < NB; i++) begin
            if (i < nbytes) begin
               mem[base_idx + IW'(i)] <= cur.wdata[8*i +: 8]; // Little-endian
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (arrive && !cur.write) begin
         rd_data <= rd_nxt;
      end
   end

   a_size_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
      push |-> cmd.size != 3'd0)
      else $error("cmd_sram: command with size 0");

endmodule

// File: source/lsu_result.sv
// Result stage: load data extension and completion pulse
`include "lsu_defs.svh"

module lsu_result (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   ld_valid,
   input  lsu_pipe_pkg::ld_rsp_t  ld_rsp,
   input  logic                   flt_valid,
   output logic                   done,
   output logic [`LSU_DW-1:0]     load_data,
   output logic                   fault
);
   import lsu_isa_pkg::*;

   logic [`LSU_DW-1:0] ext;

   always_comb begin
      case (ld_rsp.size)
         SZ_BYTE: ext = {{(`LSU_DW-8){ld_rsp.sext & ld_rsp.data[7]}},
                         ld_rsp.data[7:0]};
         SZ_HALF: ext = {{(`LSU_DW-16){ld_rsp.sext & ld_rsp.data[15]}},
                         ld_rsp.data[15:0]};
         default: ext = ld_rsp.data; // Words and stores as they come
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         done  <= 1'b0;
         fault <= 1'b0;
      end else begin
         done  <= ld_valid | flt_valid;
         fault <= flt_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_valid || flt_valid) begin
         load_data <= ld_valid ? ext : '0;
      end
   end

   a_one_source: assert property (@(posedge clk) disable iff (!arst_n)
      !(ld_valid && flt_valid))
      else $error("lsu_result: load and fault completion in one cycle");

endmodule

// File: source/lsu_top.sv
// Load/store unit top: decode, execute, command SRAM and result stages
`include "lsu_defs.svh"

module lsu_top (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  insn_valid,
   input  lsu_isa_pkg::mem_op_e  opcode,
   input  logic [`LSU_AW-1:0]    base,
   input  logic [11:0]           offset,
   input  logic [`LSU_DW-1:0]    store_data,
   output logic                  busy,
   output logic                  done,
   output logic [`LSU_DW-1:0]    load_data,
   output logic                  fault
);
   import lsu_pipe_pkg::*;

   logic               dec_valid;
   dec_op_t            dec_op;
   logic               cmd_valid;
   logic               cmd_ready;
   mem_cmd_t           cmd;
   logic               rsp_valid;
   logic               rsp_ready;
   logic [`LSU_DW-1:0] rd_data;
   logic               ld_valid;
   ld_rsp_t            ld_rsp;
   logic               flt_valid;
   logic               exe_busy;

   assign busy = exe_busy | dec_valid; // Covers the decode cycle

   lsu_decode u_decode (
      .clk(clk), .arst_n(arst_n), .insn_valid(insn_valid), .opcode(opcode),
      .base(base), .offset(offset), .store_data(store_data), .busy(busy),
      .dec_valid(dec_valid), .dec_op(dec_op)
   );

   lsu_execute u_execute (
      .clk(clk), .arst_n(arst_n), .dec_valid(dec_valid), .dec_op(dec_op),
      .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rd_data(rd_data),
      .ld_valid(ld_valid), .ld_rsp(ld_rsp), .flt_valid(flt_valid), .busy(exe_busy)
   );

   cmd_sram #(.DELAY(`SRAM_DELAY)) u_sram (
      .clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
      .cmd(cmd), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rd_data(rd_data)
   );

   lsu_result u_result (
      .clk(clk), .arst_n(arst_n), .ld_valid(ld_valid), .ld_rsp(ld_rsp),
      .flt_valid(flt_valid), .done(done), .load_data(load_data), .fault(fault)
   );

endmodule

// File: bench/lsu_tb_ref.svh
// Reference memory mirror, reference access function and LFSR for the testbench
`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

logic [7:0]  mirror [0:`SRAM_BYTES-1];
logic [19:0] lfsr_state = 20'd92775;

initial begin
   foreach (mirror[i]) mirror[i] = 8'h00;
end

// Fibonacci LFSR, x^20 + x^17 + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[18:0], lfsr_state[19] ^ lfsr_state[16]};
      v = {v[30:0], lfsr_state[0]};
   end
   return v;
endfunction

// Expected load data and fault; stores also update the mirror
function automatic logic [31:0] ref_access(input mem_op_e op, input logic [31:0] addr,
                                           input logic [31:0] wd, output logic flt);
   int          nb;
   logic        st;
   logic [31:0] raw;
   nb  = (op inside {LB, LBU, SB}) ? 1 : ((op inside {LH, LHU, SH}) ? 2 : 4);
   st  = op inside {SB, SH, SW};
   flt = (nb == 2 && addr[0]) || (nb == 4 && addr[1:0] != 2'b00);
   raw = '0;
   if (flt) return '0; // Memory stays untouched
   for (int i = 0; i < nb; i++) begin
      if (st) mirror[(addr + i) & (`SRAM_BYTES - 1)] = wd[8*i +: 8];
      else raw[8*i +: 8] = mirror[(addr + i) & (`SRAM_BYTES - 1)];
   end
   case (op)
      LB:      return {{24{raw[7]}}, raw[7:0]};
      LH:      return {{16{raw[15]}}, raw[15:0]};
      default: return raw; // Unsigned loads zero-filled, stores zero
   endcase
endfunction

`endif

// File: bench/lsu_tb.sv
// Testbench for the load/store unit with stimulus, reference compare and timeout
`include "lsu_defs.svh"

module lsu_tb;
   import lsu_isa_pkg::*;

   localparam int N_DIR  = 21;
   localparam int N_RAND = 200;
   localparam int LIMIT  = (N_DIR + N_RAND) * (`SRAM_DELAY + 6) + 16 + 100;

   logic clk, arst_n, insn_valid, busy, done, fault;
   mem_op_e opcode;
   logic [`LSU_AW-1:0] base;
   logic [11:0] offset;
   logic [`LSU_DW-1:0] store_data, load_data;

   logic [31:0] exp_data, rv, r_base;
   logic        exp_flt, busy_chk = 1'b0;
   logic [11:0] r_off;
   mem_op_e     r_op;
   string       exp_name = "none";
   int errors = 0, checks = 0, ndone = 0, ncyc = 0, t_acc = 0, cyc = 0;

   `include "lsu_tb_ref.svh"

   lsu_top dut0 (
      .clk(clk), .arst_n(arst_n), .insn_valid(insn_valid), .opcode(opcode), .base(base),
      .offset(offset), .store_data(store_data), .busy(busy), .done(done),
      .load_data(load_data), .fault(fault)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("ERROR %s %s: expected %h, actual %h", exp_name, what, exp, act);
      end
   endtask

   // Send one instruction and wait for its completion
   task automatic issue(input string name, input mem_op_e op, input logic [31:0] b,
                        input logic [11:0] off, input logic [31:0] sd);
      int target;
      exp_name = name;
      exp_data = ref_access(op, b + {{20{off[11]}}, off}, sd, exp_flt);
      target = ndone + 1;
      @(posedge clk);
      insn_valid <= 1'b1;
      opcode     <= op;
      base       <= b;
      offset     <= off;
      store_data <= sd;
      @(posedge clk);
      insn_valid <= 1'b0;
      wait (ndone == target);
   endtask

   // Compare at the falling edge where outputs are stable
   always @(negedge clk) begin
      if (arst_n) begin
         ncyc++;
         if (busy_chk) begin
            busy_chk = 1'b0;
            checks++;
            assert (!busy) else begin
               errors++;
               $display("Busy was still high in the cycle after done (%s)", exp_name);
            end
         end
         if (insn_valid && !busy) t_acc = ncyc;
         if (done) begin
            check_value("latency", exp_flt ? 3 : `SRAM_DELAY + 3, ncyc - t_acc);
            check_value("fault", {31'd0, exp_flt}, {31'd0, fault});
            check_value("load_data", exp_data, load_data);
            check_value("busy", 32'd0, {31'd0, busy});
            busy_chk = 1'b1;
            ndone++;
         end
      end
   end

   always @(posedge clk) begin
      cyc++;
      if (cyc > LIMIT) begin
         $display("Timeout: no completion within %0d cycles", LIMIT);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      arst_n     <= 1'b0;
      insn_valid <= 1'b0;
      opcode     <= LB;
      base       <= '0;
      offset     <= '0;
      store_data <= '0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      issue("word_rw", SW, 32'h100, 12'h000, 32'hDEAD_BEEF);
      issue("word_rw", LW, 32'h0F0, 12'h010, 32'h0);
      issue("lanes", SW, 32'h104, 12'h000, 32'h1122_3344);
      issue("lanes", SH, 32'h100, 12'h006, 32'hFFFF_8081);
      issue("lanes", SB, 32'h110, 12'hFF1, 32'h0000_005A); // Negative offset to 0x101
      issue("lanes", LW, 32'h100, 12'h000, 32'h0);
      issue("lanes", LW, 32'h104, 12'h000, 32'h0);
      issue("extend", SW, 32'h108, 12'h000, 32'h80F0_8AC3);
      issue("extend", LB, 32'h108, 12'h000, 32'h0);
      issue("extend", LBU, 32'h108, 12'h000, 32'h0);
      issue("extend", LH, 32'h108, 12'h002, 32'h0);
      issue("extend", LHU, 32'h108, 12'h002, 32'h0);
      issue("extend", LB, 32'h10C, 12'hFFF, 32'h0);
      issue("misalign", LH, 32'h101, 12'h000, 32'h0);
      issue("misalign", SH, 32'h103, 12'h000, 32'hFFFF_FFFF);
      issue("misalign", LW, 32'h102, 12'h000, 32'h0);
      issue("misalign", SW, 32'h10A, 12'h000, 32'h0BAD_F00D);
      issue("misalign", LW, 32'h100, 12'h000, 32'h0);
      issue("misalign", LW, 32'h104, 12'h000, 32'h0);
      issue("misalign", LW, 32'h108, 12'h000, 32'h0);
      issue("misalign", LW, 32'h10C, 12'h000, 32'h0);
      for (int k = 0; k < N_RAND; k++) begin
         rv = rand_bits(3);
         r_op = mem_op_e'(rv[2:0]);
         rv = rand_bits(6);
         r_base = 32'h200 + {24'h0, rv[5:0], 2'b00};
         rv = rand_bits(2);
         if (rv[1:0] == 2'b00) begin
            rv = rand_bits(20);
            r_base[31:12] = rv[19:0]; // Upper bits wrap
         end
         rv = rand_bits(8);
         r_off = {{4{rv[7]}}, rv[7:2], 2'b00};
         rv = rand_bits(2);
         if (rv[1:0] == 2'b00) begin
            rv = rand_bits(2);
            r_off[1:0] = rv[1:0]; // Occasional misalignment
         end
         issue("random", r_op, r_base, r_off, rand_bits(32));
      end
      repeat (2) @(posedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+source
+incdir+bench
source/lsu_isa_pkg.sv
source/lsu_pipe_pkg.sv
source/lsu_decode.sv
source/lsu_execute.sv
source/cmd_sram.sv
source/lsu_result.sv
source/lsu_top.sv
bench/lsu_tb.sv
